// ==== compile.f ====
src/tile_feat_pkg.sv
src/pix_lane_if.sv
src/tile_res_if.sv
src/pix_tile_router.sv
src/tile_stats_acc.sv
src/feature_drain.sv
src/tile_feature_top.sv
sim/tb_tile_feature.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the tile feature testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_tile_feature \
  -f compile.f -o tb_tile_feature > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_tile_feature > sim.log 2>&1 \
  || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log

grep -qx "=== PASS ===" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== sim/tb_tile_feature.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tile_feature;
  import tile_feat_pkg::*;

  localparam int W           = 16;
  localparam int H           = 8;
  localparam int FRAME_PIX   = W * H;
  localparam int TILES_W     = W / 4;
  localparam int TILES_H     = H / 4;
  localparam int NUM_TESTS   = 8;
  localparam int CYCLE_LIMIT = NUM_TESTS * FRAME_PIX * 4 + 500;

  // pattern kinds
  localparam int KIND_FLAT  = 0;
  localparam int KIND_RAMP  = 1;
  localparam int KIND_CHECK = 2;
  localparam int KIND_RAND  = 3;

  logic             clk;
  logic             rst;
  logic             pix_valid_i;
  logic             pix_ready_o;
  logic             sof_i;
  pix_t             pix_i;
  logic             feat_valid_o;
  logic             feat_ready_i;
  logic [IDX_W-1:0] tile_i_o;
  logic [IDX_W-1:0] tile_j_o;
  feat_vec_t        feat_o;

  // ----------------------------------------
  // frame table, sent back to back
  // ----------------------------------------
  string test_name [NUM_TESTS] = '{"flat_90", "ramp", "checker", "random",
                                   "random_stall", "flat_gap_stall", "checker_stall",
                                   "ramp_gap_stall"};
  int    test_kind [NUM_TESTS] = '{KIND_FLAT, KIND_RAMP, KIND_CHECK, KIND_RAND,
                                   KIND_RAND, KIND_FLAT, KIND_CHECK, KIND_RAMP};
  pix_t  test_value [NUM_TESTS] = '{8'd90, 8'd0, 8'd255, 8'd0,
                                    8'd0, 8'd255, 8'd255, 8'd0};
  logic [31:0] gap_mask [NUM_TESTS] = '{32'h0, 32'h0, 32'h0, 32'h0,
                                        32'h8421_1248, 32'h5555_0f0f, 32'h0, 32'hf0f0_1111};
  // the last two frames drain one vector per 32 cycles so the lane slots fill
  logic [31:0] stall_mask [NUM_TESTS] = '{32'h0, 32'h0, 32'h0, 32'h0,
                                          32'h9c3a_51e6, 32'h3c3c_a5a5, 32'hffff_fffe,
                                          32'hffff_fffe};

  pix_t             frame [H][W];
  feat_vec_t        exp_feat_q [$];
  logic [IDX_W-1:0] exp_i_q [$];
  logic [IDX_W-1:0] exp_j_q [$];
  string            exp_name_q [$];

  logic [31:0] lcg_state = 32'headd_1dc5;
  int          value_errs = 0;
  int          other_errs = 0;
  int          cur_test = 0;
  int          hold_cnt = 0;
  int          cycle_cnt;
  int          stall_cyc;

  tile_feature_top #(
    .ACTIVE_W (W),
    .ACTIVE_H (H)
  ) dut_i (
    .clk          (clk),
    .rst          (rst),
    .pix_valid_i  (pix_valid_i),
    .pix_ready_o  (pix_ready_o),
    .sof_i        (sof_i),
    .pix_i        (pix_i),
    .feat_valid_o (feat_valid_o),
    .feat_ready_i (feat_ready_i),
    .tile_i_o     (tile_i_o),
    .tile_j_o     (tile_j_o),
    .feat_o       (feat_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic build_frame(input int t);
    int x;
    int y;
    for (y = 0; y < H; y++) begin
      for (x = 0; x < W; x++) begin
        case (test_kind[t])
          KIND_FLAT:  frame[y][x] = test_value[t];
          KIND_RAMP:  frame[y][x] = pix_t'(4 * x);
          KIND_CHECK: frame[y][x] = ((x + y) % 2 == 1) ? test_value[t] : 8'd0;
          default: begin
            lcg_state   = next_lcg(lcg_state);
            frame[y][x] = lcg_state[23:16];
          end
        endcase
      end
    end
  endtask

  // reference model, tiles in raster order
  task automatic predict_tiles(input int t);
    int        ti;
    int        tj;
    int        r;
    int        c;
    int        p;
    int        prev;
    int        sum;
    int        mn;
    int        mx;
    int        edge_acc;
    feat_vec_t f;
    for (ti = 0; ti < TILES_H; ti++) begin
      for (tj = 0; tj < TILES_W; tj++) begin
        sum      = 0;
        mn       = 255;
        mx       = 0;
        edge_acc = 0;
        prev     = 0;
        for (r = 0; r < 4; r++) begin
          for (c = 0; c < 4; c++) begin
            p   = int'(frame[ti * 4 + r][tj * 4 + c]);
            sum = sum + p;
            if (p < mn) mn = p;
            if (p > mx) mx = p;
            // pairs only inside one tile row
            if (c > 0) edge_acc = edge_acc + ((p > prev) ? p - prev : prev - p);
            prev = p;
          end
        end
        f.mean     = FEAT_W'(sum >> 4);
        f.range    = FEAT_W'(mx - mn);
        f.edge_sum = FEAT_W'(edge_acc);
        f.max      = FEAT_W'(mx);
        exp_feat_q.push_back(f);
        exp_i_q.push_back(IDX_W'(ti));
        exp_j_q.push_back(IDX_W'(tj));
        exp_name_q.push_back(test_name[t]);
      end
    end
  endtask

  // holds valid until the pixel is taken
  task automatic send_pixel(input pix_t p, input logic sof, input logic tile_end);
    logic done;
    pix_valid_i = 1'b1;
    pix_i       = p;
    sof_i       = sof;
    done        = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = pix_ready_o;
      if (!done) begin
        hold_cnt++;
        // only a tile's last pixel may wait for a result slot
        if (!tile_end) begin
          other_errs++;
          $display("pixel input stalled on a pixel that does not end a tile");
        end
      end
      @(posedge clk);
      #2;
    end
    pix_valid_i = 1'b0;
    sof_i       = 1'b0;
  endtask

  task automatic send_frame(input int t);
    int k;
    for (k = 0; k < FRAME_PIX; k++) begin
      if (gap_mask[t][k % 32]) begin
        pix_valid_i = 1'b0;
        @(posedge clk);
        #2;
      end
      send_pixel(frame[k / W][k % W], k == 0,
                 ((k % W) % 4 == 3) && ((k / W) % 4 == 3));
    end
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_feat(input string name, input feat_vec_t exp, input feat_vec_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERROR %s feat expected mean=%0d range=%0d edge=%0d max=%0d actual %0d %0d %0d %0d",
               name, exp.mean, exp.range, exp.edge_sum, exp.max,
               act.mean, act.range, act.edge_sum, act.max);
    end
  endtask

  task automatic check_index(input string name, input logic [IDX_W-1:0] exp_i,
                             input logic [IDX_W-1:0] exp_j, input logic [IDX_W-1:0] act_i,
                             input logic [IDX_W-1:0] act_j);
    if (act_i !== exp_i || act_j !== exp_j) begin
      value_errs++;
      $display("ERROR %s tile index expected (%0d,%0d) actual (%0d,%0d)",
               name, exp_i, exp_j, act_i, act_j);
    end
  endtask

  // output back-pressure, sampled at the falling edge
  initial begin
    feat_ready_i = 1'b0;
    stall_cyc    = 0;
    forever begin
      @(posedge clk);
      #2;
      feat_ready_i = !stall_mask[cur_test][stall_cyc % 32];
      stall_cyc++;
    end
  end

  // monitor
  initial begin
    forever begin
      @(negedge clk);
      if (rst === 1'b0 && feat_valid_o && feat_ready_i) begin
        if (exp_feat_q.size() == 0) begin
          other_errs++;
          $display("feature vector for tile (%0d,%0d) came out with none outstanding",
                   tile_i_o, tile_j_o);
        end else begin
          check_feat(exp_name_q[0], exp_feat_q[0], feat_o);
          check_index(exp_name_q[0], exp_i_q[0], exp_j_q[0], tile_i_o, tile_j_o);
          void'(exp_feat_q.pop_front());
          void'(exp_i_q.pop_front());
          void'(exp_j_q.pop_front());
          void'(exp_name_q.pop_front());
        end
      end
    end
  end

  // watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run hung after %0d cycles with %0d features outstanding",
             cycle_cnt, exp_feat_q.size());
    $display("errors: %0d value, %0d other", value_errs, other_errs + 1);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int t;
    rst         = 1'b1;
    pix_valid_i = 1'b0;
    sof_i       = 1'b0;
    pix_i       = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    for (t = 0; t < NUM_TESTS; t++) begin
      cur_test = t;
      build_frame(t);
      predict_tiles(t);
      send_frame(t);
    end
    while (exp_feat_q.size() > 0) @(posedge clk);
    // room for a stray extra vector to show up
    repeat (20) @(posedge clk);
    if (hold_cnt == 0) begin
      other_errs++;
      $display("back-pressure never reached the pixel input");
    end
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/tile_feature_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_feature_top #(
  parameter int unsigned ACTIVE_W = 16,
  parameter int unsigned ACTIVE_H = 8
) (
  input  logic                            clk,
  input  logic                            rst,

  // pixel stream in
  input  logic                            pix_valid_i,
  output logic                            pix_ready_o,
  input  logic                            sof_i,
  input  tile_feat_pkg::pix_t             pix_i,

  // feature stream out
  output logic                            feat_valid_o,
  input  logic                            feat_ready_i,
  output logic [tile_feat_pkg::IDX_W-1:0] tile_i_o,
  output logic [tile_feat_pkg::IDX_W-1:0] tile_j_o,
  output tile_feat_pkg::feat_vec_t        feat_o
);
  import tile_feat_pkg::*;

  // one lane per tile column
  localparam int unsigned TILES_X = ACTIVE_W / TILE_DIM;

  pix_lane_if lane_bus [TILES_X] ();
  tile_res_if res_bus  [TILES_X] ();

  // ----------------------------------------
  // raster position to lane
  // ----------------------------------------
  pix_tile_router #(
    .ACTIVE_W (ACTIVE_W),
    .ACTIVE_H (ACTIVE_H)
  ) u_router (
    .clk         (clk),
    .rst         (rst),
    .pix_valid_i (pix_valid_i),
    .pix_ready_o (pix_ready_o),
    .sof_i       (sof_i),
    .pix_i       (pix_i),
    .lanes       (lane_bus)
  );

  // ----------------------------------------
  // per-column accumulators
  // ----------------------------------------
  for (genvar g = 0; g < TILES_X; g++) begin : g_acc
    tile_stats_acc u_acc (
      .clk     (clk),
      .rst     (rst),
      .pix_in  (lane_bus[g]),
      .res_out (res_bus[g])
    );
  end

  // in-order collect and pack
  feature_drain #(
    .ACTIVE_W (ACTIVE_W),
    .ACTIVE_H (ACTIVE_H)
  ) u_drain (
    .clk          (clk),
    .rst          (rst),
    .res_in       (res_bus),
    .feat_valid_o (feat_valid_o),
    .feat_ready_i (feat_ready_i),
    .tile_i_o     (tile_i_o),
    .tile_j_o     (tile_j_o),
    .feat_o       (feat_o)
  );

endmodule

`default_nettype wire

// ==== src/feature_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

module feature_drain #(
  parameter int unsigned ACTIVE_W = 16,
  parameter int unsigned ACTIVE_H = 8,
  localparam int unsigned TILES_X = ACTIVE_W / tile_feat_pkg::TILE_DIM
) (
  input  logic                            clk,
  input  logic                            rst,
  tile_res_if.drain                       res_in [TILES_X],
  output logic                            feat_valid_o,
  input  logic                            feat_ready_i,
  output logic [tile_feat_pkg::IDX_W-1:0] tile_i_o,
  output logic [tile_feat_pkg::IDX_W-1:0] tile_j_o,
  output tile_feat_pkg::feat_vec_t        feat_o
);
  import tile_feat_pkg::*;

  localparam int unsigned LANE_W  = (TILES_X > 1) ? $clog2(TILES_X) : 1;
  localparam int unsigned TILES_Y = ACTIVE_H / TILE_DIM;

  logic [LANE_W-1:0]  exp_q;
  logic [IDX_W-1:0]   row_q;
  logic [TILES_X-1:0] valid_vec;
  tile_stats_t        stats_vec [TILES_X];
  tile_stats_t        sel_stats;
  logic               sel_valid;
  logic               out_free;
  logic               take;
  feat_vec_t          feat_nxt;

  logic               feat_valid_q;
  feat_vec_t          feat_q;
  logic [IDX_W-1:0]   tile_i_q;
  logic [IDX_W-1:0]   tile_j_q;

  // output register empty, or leaving this cycle
  assign out_free = !feat_valid_q || feat_ready_i;

  // ----------------------------------------
  // lane gather, only the expected lane sees ready
  // ----------------------------------------
  for (genvar l = 0; l < TILES_X; l++) begin : g_lane
    assign valid_vec[l]    = res_in[l].valid;
    assign stats_vec[l]    = res_in[l].stats;
    assign res_in[l].ready = out_free && (exp_q == LANE_W'(l));
  end

  assign sel_valid = valid_vec[exp_q];
  assign sel_stats = stats_vec[exp_q];
  assign take      = sel_valid && out_free;

  // feature packing
  always_comb begin
    feat_nxt.mean     = FEAT_W'(sel_stats.sum >> (2 * TILE_SHIFT));
    feat_nxt.range    = FEAT_W'(sel_stats.max - sel_stats.min);
    feat_nxt.edge_sum = FEAT_W'(sel_stats.edge_sum);
    feat_nxt.max      = FEAT_W'(sel_stats.max);
  end

  // tile column pointer and tile row
  always_ff @(posedge clk) begin
    if (rst) begin
      exp_q <= '0;
      row_q <= '0;
    end else if (take) begin
      if (exp_q == LANE_W'(TILES_X - 1)) begin
        exp_q <= '0;
        row_q <= (row_q == IDX_W'(TILES_Y - 1)) ? '0 : row_q + 1'b1;
      end else begin
        exp_q <= exp_q + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // output stage
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      feat_valid_q <= 1'b0;
    end else if (take) begin
      feat_valid_q <= 1'b1;
    end else if (feat_ready_i) begin
      feat_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      feat_q   <= feat_nxt;
      tile_i_q <= row_q;
      tile_j_q <= IDX_W'(exp_q);
    end
  end

  assign feat_valid_o = feat_valid_q;
  assign feat_o       = feat_q;
  assign tile_i_o     = tile_i_q;
  assign tile_j_o     = tile_j_q;

  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (rst)
    (feat_valid_o && !feat_ready_i) |=>
      (feat_valid_o && $stable(feat_o) && $stable(tile_i_o) && $stable(tile_j_o))
  );

endmodule

`default_nettype wire

// ==== src/tile_stats_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_stats_acc (
  input  logic      clk,
  input  logic      rst,
  pix_lane_if.lane  pix_in,
  tile_res_if.lane  res_out
);
  import tile_feat_pkg::*;

  logic [TILE_SHIFT-1:0] col_q;
  logic                  res_valid_q;
  tile_stats_t           acc_q;
  tile_stats_t           acc_nxt;
  tile_stats_t           slot_q;
  pix_t                  prev_q;
  pix_t                  diff;
  logic                  pix_acc;
  logic                  last_acc;

  // hold off only the pixel that would overwrite a pending result
  assign pix_in.ready = !(res_valid_q && pix_in.last);
  assign pix_acc      = pix_in.valid && pix_in.ready;
  assign last_acc     = pix_acc && pix_in.last;

  assign diff = (pix_in.pix > prev_q) ? (pix_in.pix - prev_q) : (prev_q - pix_in.pix);

  // ----------------------------------------
  // running statistics
  // ----------------------------------------
  always_comb begin
    if (pix_in.first) begin
      acc_nxt.sum      = SUM_W'(pix_in.pix);
      acc_nxt.min      = pix_in.pix;
      acc_nxt.max      = pix_in.pix;
      acc_nxt.edge_sum = '0;
    end else begin
      acc_nxt.sum = acc_q.sum + SUM_W'(pix_in.pix);
      acc_nxt.min = (pix_in.pix < acc_q.min) ? pix_in.pix : acc_q.min;
      acc_nxt.max = (pix_in.pix > acc_q.max) ? pix_in.pix : acc_q.max;
      // no pair across a tile row boundary
      if (col_q != '0) begin
        acc_nxt.edge_sum = acc_q.edge_sum + EDGE_W'(diff);
      end else begin
        acc_nxt.edge_sum = acc_q.edge_sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pix_acc) begin
      acc_q  <= acc_nxt;
      prev_q <= pix_in.pix;
    end
    if (last_acc) begin
      slot_q <= acc_nxt;
    end
  end

  // column within the tile, 4 pixels per tile row
  always_ff @(posedge clk) begin
    if (rst) begin
      col_q <= '0;
    end else if (pix_acc) begin
      col_q <= col_q + 1'b1;
    end
  end

  // ----------------------------------------
  // result slot
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid_q <= 1'b0;
    end else if (last_acc) begin
      res_valid_q <= 1'b1;
    end else if (res_out.ready) begin
      res_valid_q <= 1'b0;
    end
  end

  assign res_out.valid = res_valid_q;
  assign res_out.stats = slot_q;

  // a pending result stays put until the drain takes it
  a_no_slot_overwrite: assert property (
    @(posedge clk) disable iff (rst)
    (res_valid_q && !res_out.ready) |=> (res_valid_q && $stable(slot_q))
  );

  // router tile marks agree with the lane's own column count
  a_marks_aligned: assert property (
    @(posedge clk) disable iff (rst)
    pix_acc |-> (!pix_in.first || col_q == '0) && (!pix_in.last || &col_q)
  );

endmodule

`default_nettype wire

// ==== src/pix_tile_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module pix_tile_router #(
  parameter int unsigned ACTIVE_W = 16,
  parameter int unsigned ACTIVE_H = 8,
  localparam int unsigned TILES_X = ACTIVE_W / tile_feat_pkg::TILE_DIM
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                pix_valid_i,
  output logic                pix_ready_o,
  input  logic                sof_i,
  input  tile_feat_pkg::pix_t pix_i,
  pix_lane_if.router          lanes [TILES_X]
);
  import tile_feat_pkg::*;

  localparam int unsigned LANE_W = (TILES_X > 1) ? $clog2(TILES_X) : 1;
  localparam int unsigned X_W    = LANE_W + TILE_SHIFT;
  localparam int unsigned Y_W    = $clog2(ACTIVE_H);

  logic [X_W-1:0]     x_q;
  logic [Y_W-1:0]     y_q;
  logic [X_W-1:0]     cur_x;
  logic [Y_W-1:0]     cur_y;
  logic [LANE_W-1:0]  lane_idx;
  logic [TILES_X-1:0] lane_ready;
  logic               tile_first;
  logic               tile_last;
  logic               pix_acc;

  // sof pins the current pixel to the frame origin
  assign cur_x = sof_i ? '0 : x_q;
  assign cur_y = sof_i ? '0 : y_q;

  assign lane_idx   = cur_x[X_W-1:TILE_SHIFT];
  assign tile_first = (cur_x[TILE_SHIFT-1:0] == '0) && (cur_y[TILE_SHIFT-1:0] == '0);
  assign tile_last  = (&cur_x[TILE_SHIFT-1:0]) && (&cur_y[TILE_SHIFT-1:0]);

  assign pix_ready_o = lane_ready[lane_idx];
  assign pix_acc     = pix_valid_i && pix_ready_o;

  // ----------------------------------------
  // demux onto the lanes
  // ----------------------------------------
  for (genvar l = 0; l < TILES_X; l++) begin : g_lane
    assign lanes[l].valid = pix_valid_i && (lane_idx == LANE_W'(l));
    assign lanes[l].pix   = pix_i;
    assign lanes[l].first = tile_first;
    assign lanes[l].last  = tile_last;
    assign lane_ready[l]  = lanes[l].ready;
  end

  // raster position counters
  always_ff @(posedge clk) begin
    if (rst) begin
      x_q <= '0;
      y_q <= '0;
    end else if (pix_acc) begin
      if (cur_x == X_W'(ACTIVE_W - 1)) begin
        x_q <= '0;
        y_q <= (cur_y == Y_W'(ACTIVE_H - 1)) ? '0 : cur_y + 1'b1;
      end else begin
        x_q <= cur_x + 1'b1;
        y_q <= cur_y;
      end
    end
  end

  // x wraps before it can address a lane that does not exist
  a_lane_in_range: assert property (
    @(posedge clk) disable iff (rst)
    pix_valid_i |-> (lane_idx < TILES_X)
  );

endmodule

`default_nettype wire

// ==== src/tile_res_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface tile_res_if;
  import tile_feat_pkg::*;

  logic        valid;
  logic        ready;
  tile_stats_t stats;

  // one finished tile per handshake
  modport lane (
    output valid, stats,
    input  ready
  );

  modport drain (
    input  valid, stats,
    output ready
  );

endinterface

`default_nettype wire

// ==== src/pix_lane_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pix_lane_if;
  import tile_feat_pkg::*;

  logic valid;
  logic ready;
  pix_t pix;
  // tile position marks
  logic first;
  logic last;

  modport router (
    output valid, pix, first, last,
    input  ready
  );

  modport lane (
    input  valid, pix, first, last,
    output ready
  );

endinterface

`default_nettype wire

// ==== src/tile_feat_pkg.sv ====
`default_nettype none

package tile_feat_pkg;

  // ----------------------------------------
  // pixel and tile geometry
  // ----------------------------------------
  localparam int unsigned PIX_W      = 8;
  localparam int unsigned TILE_SHIFT = 2;
  localparam int unsigned TILE_DIM   = 1 << TILE_SHIFT;

  // 16 * 255 = 4080 fits in 12 bits
  localparam int unsigned SUM_W  = 12;
  // 12 pairs * 255 = 3060
  localparam int unsigned EDGE_W = 12;

  localparam int unsigned FEAT_W = 16;
  localparam int unsigned IDX_W  = 8;

  // ----------------------------------------
  // types
  // ----------------------------------------
  typedef logic [PIX_W-1:0] pix_t;

  // raw statistics of one 4x4 tile
  typedef struct packed {
    logic [SUM_W-1:0]  sum;
    pix_t              min;
    pix_t              max;
    logic [EDGE_W-1:0] edge_sum;
  } tile_stats_t;

  // feature vector, mean in the top bits
  typedef struct packed {
    logic [FEAT_W-1:0] mean;
    logic [FEAT_W-1:0] range;
    logic [FEAT_W-1:0] edge_sum;
    logic [FEAT_W-1:0] max;
  } feat_vec_t;

endpackage

`default_nettype wire
